/* verilog.f */
ts_pkg.sv
sprite_file.sv
sprite_walker.sv
tile_walker.sv
layer_sequencer.sv
video_ts.sv
ts_tb_models.sv
video_ts_tb.sv

/* Makefile */
SRCS := $(shell cat verilog.f)

.PHONY: all run clean

all: obj_dir/Vvideo_ts_tb

obj_dir/Vvideo_ts_tb: verilog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module video_ts_tb -f verilog.f

run: obj_dir/Vvideo_ts_tb
	./obj_dir/Vvideo_ts_tb | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* video_ts_tb.sv */
`timescale 1ns/1ps

module video_ts_tb;

	typedef logic [42:0] req_t;

	logic                clk;
	logic                rst;
	logic                start;
	ts_pkg::ts_coord_t   line;
	logic [7:0]          tsconf;
	ts_pkg::ts_page_t    t0gpage;
	ts_pkg::ts_page_t    t1gpage;
	ts_pkg::ts_page_t    sgpage;
	ts_pkg::ts_tcount_t  num_tiles;
	ts_pkg::ts_coord_t   t0x_offs;
	ts_pkg::ts_coord_t   t0y_offs;
	ts_pkg::ts_coord_t   t1x_offs;
	ts_pkg::ts_coord_t   t1y_offs;
	logic [1:0]          t0_palsel;
	logic [1:0]          t1_palsel;
	ts_pkg::ts_sf_addr_t sf_waddr;
	ts_pkg::ts_word_t    sf_wdata;
	logic                sf_we;
	ts_pkg::ts_tm_addr_t tmb_raddr;
	ts_pkg::ts_word_t    tmb_rdata;
	logic                tsr_go;
	ts_pkg::ts_coord_t   tsr_x;
	ts_pkg::ts_size_t    tsr_xs;
	logic                tsr_xf;
	ts_pkg::ts_page_t    tsr_page;
	ts_pkg::ts_row_t     tsr_row;
	ts_pkg::ts_tnum_t    tsr_tnum;
	ts_pkg::ts_pal_t     tsr_pal;
	logic                tsr_ready;
	logic                ts_done;

	logic                rand_ready;
	logic                tm_we;
	ts_pkg::ts_tm_addr_t tm_waddr;
	ts_pkg::ts_word_t    tm_wdata;

	// expected requests of all tests, in order
	req_t             exp_list [0:2047];
	int               exp_cnt = 0;
	int               exp_ptr = 0;
	req_t             exp_cur;
	req_t             act_word;
	ts_pkg::ts_word_t spr [0:127];
	ts_pkg::ts_word_t tmap [0:511];
	logic [31:0]      seed;
	int               errors = 0;
	int               tests = 0;
	int               cycles = 0;
	int               limit = 20;
	string            test_name = "reset";

	video_ts dut0 (.*);

	ts_tb_tilemap tmap0 (
		.clk(clk), .we(tm_we), .waddr(tm_waddr), .wdata(tm_wdata),
		.raddr(tmb_raddr), .rdata(tmb_rdata)
	);

	ts_tb_renderer rend0 (.clk(clk), .rst(rst), .rand_en(rand_ready), .ready(tsr_ready));

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	assign exp_cur  = exp_list[exp_ptr[10:0]];
	assign act_word = {tsr_x, tsr_xs, tsr_xf, tsr_page, tsr_row, tsr_tnum, tsr_pal};

	always @(posedge clk)
	begin
		if (tsr_go)
			exp_ptr <= exp_ptr + 1;
	end

	always @(posedge clk)
	begin
		if (cycles >= limit)
		begin
			$display("timeout: no end of test %s after %0d cycles", test_name, cycles);
			$display("ERRORS FOUND");
			$finish;
		end
		else
			cycles <= cycles + 1;
	end

	assert property (@(posedge clk) disable iff (rst) tsr_go |-> tsr_ready)
	else
	begin
		$display("test %s: tsr_go was high while tsr_ready was low", test_name);
		errors++;
	end

	assert property (@(posedge clk) disable iff (rst) tsr_go |-> exp_ptr < exp_cnt)
	else
	begin
		$display("test %s: request arrived after the last expected one", test_name);
		errors++;
	end

	assert property (@(posedge clk) disable iff (rst)
		tsr_go && exp_ptr < exp_cnt |-> act_word == exp_cur)
	else
	begin
		$display("error %s: expected %h, actual %h", test_name,
			$sampled(exp_cur), $sampled(act_word));
		errors++;
	end

	assert property (@(posedge clk) disable iff (rst) ts_done && !start |=> ts_done)
	else
	begin
		$display("test %s: ts_done fell without a start", test_name);
		errors++;
	end

	assert property (@(posedge clk) disable iff (rst)
		start && tsconf[7:5] != 3'b000 |=> !ts_done)
	else
	begin
		$display("test %s: ts_done stayed high after start", test_name);
		errors++;
	end

	assert property (@(posedge clk) disable iff (rst) $rose(ts_done) |-> exp_ptr == exp_cnt)
	else
	begin
		$display("test %s: ts_done rose before all requests were sent", test_name);
		errors++;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic draw(output logic [31:0] r);
		seed = lcg_next(seed);
		r = seed;
	endtask

	task automatic push_req(input req_t r);
		exp_list[exp_cnt[10:0]] = r;
		exp_cnt++;
	endtask

	task automatic fill_tilemap();
		logic [31:0]      r;
		ts_pkg::ts_word_t w;
		limit += 530;
		for (int a = 0; a < 512; a++)
		begin
			draw(r);
			w = r[31:16];
			// about a quarter of the entries are empty
			if (r[5:4] == 2'b00)
				w[11:0] = '0;
			tmap[a] = w;
			@(negedge clk);
			tm_we    = 1'b1;
			tm_waddr = ts_pkg::ts_tm_addr_t'(a);
			tm_wdata = w;
		end
		@(negedge clk);
		tm_we = 1'b0;
	endtask

	// mix of active, inactive, leap and off-line sprites around line ln
	task automatic make_sprites(input ts_pkg::ts_coord_t ln, input int leap_den,
		input int off_den);
		logic [31:0]      r0;
		logic [31:0]      r1;
		logic [31:0]      r2;
		ts_pkg::ts_size_t ys;
		ts_pkg::ts_coord_t y;
		logic             on;
		logic             leap;
		limit += 140;
		for (int d = 0; d < 42; d++)
		begin
			draw(r0);
			draw(r1);
			draw(r2);
			ys   = r0[18:16];
			on   = (int'(r0[31:24]) % off_den) != 0;
			leap = (int'(r1[31:24]) % leap_den) == 0;
			if (on)
				y = ts_pkg::ts_coord_t'(int'(ln) - int'(r0[15:10]) % ((int'(ys) + 1) * 8));
			else
				y = ts_pkg::ts_coord_t'(int'(ln) + 1 + int'(r0[15:10]));
			spr[3*d]     = {r0[22], leap, r0[21:19] != 3'b000, 1'b0, ys, y};
			spr[3*d + 1] = {r1[15], 3'b000, r1[18:16], r1[8:0]};
			spr[3*d + 2] = r2[31:16];
		end
		spr[126] = '0;
		spr[127] = '0;
		for (int a = 0; a < 128; a++)
		begin
			@(negedge clk);
			sf_we    = 1'b1;
			sf_waddr = ts_pkg::ts_sf_addr_t'(a);
			sf_wdata = spr[a];
		end
		@(negedge clk);
		sf_we = 1'b0;
	endtask

	// walk the enabled layers as the renderer should see them
	task automatic build_expected();
		int                sidx;
		logic              fin;
		logic              sel;
		ts_pkg::ts_word_t  w;
		ts_pkg::ts_coord_t dy;
		ts_pkg::ts_coord_t yl;
		ts_pkg::ts_coord_t xo;
		ts_pkg::ts_row_t   row;
		logic [5:0]        col;
		ts_pkg::ts_tm_addr_t addr;
		sidx = 0;
		for (int l = 0; l < 5; l++)
		begin
			if ((l % 2) == 0 && tsconf[ts_pkg::CFG_S_EN])
			begin
				fin = 1'b0;
				while (!fin)
				begin
					if (sidx == 126)
						fin = 1'b1;
					else
					begin
						w  = spr[sidx];
						dy = line - w[8:0];
						if (w[13] && int'(dy) < (int'(w[11:9]) + 1) * 8)
						begin
							row = w[15] ? ts_pkg::ts_row_t'(int'(w[11:9]) * 8 + 7 - int'(dy)) :
								dy[5:0];
							push_req({spr[sidx+1][8:0], spr[sidx+1][11:9], spr[sidx+1][15],
								sgpage, row, spr[sidx+2][11:0], spr[sidx+2][15:12]});
						end
						fin  = w[14];
						sidx += 3;
					end
				end
			end
			else if ((l == 1 && tsconf[ts_pkg::CFG_T0_EN]) ||
				(l == 3 && tsconf[ts_pkg::CFG_T1_EN]))
			begin
				sel = l == 3;
				xo  = sel ? t1x_offs : t0x_offs;
				yl  = line + (sel ? t1y_offs : t0y_offs);
				for (int t = 0; t < int'(num_tiles); t++)
				begin
					col  = xo[8:3] + 6'(t);
					addr = {yl[4:3], col, sel};
					w    = tmap[addr];
					if (w[11:0] != 12'h000)
					begin
						// flipped tiles count their lines from the bottom
						row = ts_pkg::ts_row_t'(w[15] ? 7 - int'(yl[2:0]) : int'(yl[2:0]));
						push_req({ts_pkg::ts_coord_t'(t * 8 - int'(xo[2:0])), 3'b000, w[14],
							sel ? t1gpage : t0gpage, row,
							w[11:0], sel ? t1_palsel : t0_palsel, w[13:12]});
					end
				end
			end
		end
	endtask

	task automatic run_line(input string name, input ts_pkg::ts_coord_t ln,
		input logic [7:0] cfg);
		int base;
		int errs0;
		@(negedge clk);
		test_name = name;
		line      = ln;
		tsconf    = cfg;
		base      = exp_cnt;
		errs0     = errors;
		build_expected();
		limit += 40 * (exp_cnt - base) + 200;
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		while (!ts_done)
			@(negedge clk);
		repeat (3) @(negedge clk);
		assert (exp_ptr == exp_cnt)
		else
		begin
			$display("error %s: expected %0d requests, actual %0d", name,
				exp_cnt - base, exp_ptr - base);
			errors++;
		end
		tests++;
		$display("test %s: %0d requests, %s", name, exp_cnt - base,
			errors == errs0 ? "ok" : "failed");
	endtask

	initial
	begin
		rst = 1'b1;
		start = 1'b0;
		line = '0;
		tsconf = '0;
		t0gpage = 8'h21;
		t1gpage = 8'h42;
		sgpage = 8'h63;
		num_tiles = 6'd40;
		t0x_offs = 9'd13;
		t0y_offs = 9'd5;
		t1x_offs = 9'd300;
		t1y_offs = 9'd77;
		t0_palsel = 2'd1;
		t1_palsel = 2'd2;
		sf_waddr = '0;
		sf_wdata = '0;
		sf_we = 1'b0;
		tm_we = 1'b0;
		tm_waddr = '0;
		tm_wdata = '0;
		rand_ready = 1'b0;
		seed = 32'h1168_4a7a;
		repeat (8) @(negedge clk);
		rst = 1'b0;
		fill_tilemap();

		make_sprites(9'd100, 12, 4);
		run_line("all_layers", 9'd100, 8'he0);

		// many skips and early leaps
		make_sprites(9'd200, 5, 2);
		run_line("skip_leap", 9'd200, 8'h80);

		t0x_offs  = 9'd7;
		t1y_offs  = 9'd510;
		num_tiles = 6'd63;
		run_line("tiles", 9'd37, 8'h60);

		rand_ready = 1'b1;
		num_tiles  = 6'd40;
		make_sprites(9'd150, 12, 4);
		run_line("random_ready", 9'd150, 8'he0);
		rand_ready = 1'b0;

		make_sprites(9'd60, 8, 3);
		run_line("bypass_t1", 9'd60, 8'ha0);
		run_line("bypass_sprites", 9'd61, 8'h40);
		run_line("no_layers", 9'd62, 8'h00);

		$display("tests run %0d, failed checks %0d", tests, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* ts_tb_models.sv */
`timescale 1ns/1ps

// tile-map buffer with a host write port and one cycle of read latency
module ts_tb_tilemap (
	input  logic                clk,
	input  logic                we,
	input  ts_pkg::ts_tm_addr_t waddr,
	input  ts_pkg::ts_word_t    wdata,
	input  ts_pkg::ts_tm_addr_t raddr,
	output ts_pkg::ts_word_t    rdata
);

	ts_pkg::ts_word_t mem [0:511];

	always @(posedge clk)
	begin
		if (we)
		begin
			mem[waddr] <= wdata;
		end
		rdata <= mem[raddr];
	end

endmodule

// renderer stand-in, only the ready level matters here
module ts_tb_renderer (
	input  logic clk,
	input  logic rst,
	input  logic rand_en,
	output logic ready
);

	logic [31:0] state = 32'h1168_4a7a;

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	initial ready = 1'b1;

	// busy about a quarter of the time when random
	always @(negedge clk)
	begin
		state <= lcg_step(state);
		if (rst || !rand_en)
			ready <= 1'b1;
		else
			ready <= state[29:28] != 2'b00;
	end

endmodule

/* video_ts.sv */
`timescale 1ns/1ps

module video_ts (
	input  logic                clk,
	input  logic                rst,
	input  logic                start,
	input  ts_pkg::ts_coord_t   line,
	input  logic [7:0]          tsconf,
	input  ts_pkg::ts_page_t    t0gpage,
	input  ts_pkg::ts_page_t    t1gpage,
	input  ts_pkg::ts_page_t    sgpage,
	input  ts_pkg::ts_tcount_t  num_tiles,
	input  ts_pkg::ts_coord_t   t0x_offs,
	input  ts_pkg::ts_coord_t   t0y_offs,
	input  ts_pkg::ts_coord_t   t1x_offs,
	input  ts_pkg::ts_coord_t   t1y_offs,
	input  logic [1:0]          t0_palsel,
	input  logic [1:0]          t1_palsel,
	input  ts_pkg::ts_sf_addr_t sf_waddr,
	input  ts_pkg::ts_word_t    sf_wdata,
	input  logic                sf_we,
	output ts_pkg::ts_tm_addr_t tmb_raddr,
	input  ts_pkg::ts_word_t    tmb_rdata,
	output logic                tsr_go,
	output ts_pkg::ts_coord_t   tsr_x,
	output ts_pkg::ts_size_t    tsr_xs,
	output logic                tsr_xf,
	output ts_pkg::ts_page_t    tsr_page,
	output ts_pkg::ts_row_t     tsr_row,
	output ts_pkg::ts_tnum_t    tsr_tnum,
	output ts_pkg::ts_pal_t     tsr_pal,
	input  logic                tsr_ready,
	output logic                ts_done
);

	// sprite file read side
	ts_pkg::ts_sf_addr_t sf_raddr;
	ts_pkg::ts_word_t    sf_rdata;

	// sequencer controls
	logic spr_run;
	logic til_run;
	logic til_sel1;
	logic spr_end;
	logic til_end;

	// sprite request bus
	logic              spr_go;
	ts_pkg::ts_coord_t spr_x;
	ts_pkg::ts_size_t  spr_xs;
	logic              spr_xf;
	ts_pkg::ts_page_t  spr_page;
	ts_pkg::ts_row_t   spr_row;
	ts_pkg::ts_tnum_t  spr_tnum;
	ts_pkg::ts_pal_t   spr_pal;

	// tile request bus
	logic              til_go;
	ts_pkg::ts_coord_t til_x;
	ts_pkg::ts_size_t  til_xs;
	logic              til_xf;
	ts_pkg::ts_page_t  til_page;
	ts_pkg::ts_row_t   til_row;
	ts_pkg::ts_tnum_t  til_tnum;
	ts_pkg::ts_pal_t   til_pal;

	sprite_file u_sf (
		.clk(clk),
		.waddr(sf_waddr), .wdata(sf_wdata), .we(sf_we),
		.raddr(sf_raddr), .rdata(sf_rdata)
	);

	sprite_walker u_spr (
		.clk(clk), .rst(rst), .start(start), .run(spr_run),
		.line(line), .sgpage(sgpage), .ready(tsr_ready),
		.sf_raddr(sf_raddr), .sf_rdata(sf_rdata),
		.go(spr_go), .x(spr_x), .xs(spr_xs), .xf(spr_xf),
		.page(spr_page), .row(spr_row), .tnum(spr_tnum), .pal(spr_pal),
		.layer_end(spr_end)
	);

	tile_walker u_til (
		.clk(clk), .rst(rst), .start(start), .run(til_run), .sel1(til_sel1),
		.line(line), .num_tiles(num_tiles),
		.t0x_offs(t0x_offs), .t0y_offs(t0y_offs),
		.t1x_offs(t1x_offs), .t1y_offs(t1y_offs),
		.t0gpage(t0gpage), .t1gpage(t1gpage),
		.t0_palsel(t0_palsel), .t1_palsel(t1_palsel),
		.ready(tsr_ready), .tmb_raddr(tmb_raddr), .tmb_rdata(tmb_rdata),
		.go(til_go), .x(til_x), .xs(til_xs), .xf(til_xf),
		.page(til_page), .row(til_row), .tnum(til_tnum), .pal(til_pal),
		.layer_end(til_end)
	);

	layer_sequencer u_seq (
		.clk(clk), .rst(rst), .start(start), .tsconf(tsconf),
		.spr_end(spr_end), .til_end(til_end),
		.spr_run(spr_run), .til_run(til_run), .til_sel1(til_sel1),
		.spr_go(spr_go), .spr_x(spr_x), .spr_xs(spr_xs), .spr_xf(spr_xf),
		.spr_page(spr_page), .spr_row(spr_row), .spr_tnum(spr_tnum), .spr_pal(spr_pal),
		.til_go(til_go), .til_x(til_x), .til_xs(til_xs), .til_xf(til_xf),
		.til_page(til_page), .til_row(til_row), .til_tnum(til_tnum), .til_pal(til_pal),
		.tsr_go(tsr_go), .tsr_x(tsr_x), .tsr_xs(tsr_xs), .tsr_xf(tsr_xf),
		.tsr_page(tsr_page), .tsr_row(tsr_row), .tsr_tnum(tsr_tnum), .tsr_pal(tsr_pal),
		.ts_done(ts_done)
	);

endmodule

/* layer_sequencer.sv */
`timescale 1ns/1ps

module layer_sequencer (
	input  logic               clk,
	input  logic               rst,
	input  logic               start,
	input  logic [7:0]         tsconf,
	input  logic               spr_end,
	input  logic               til_end,
	output logic               spr_run,
	output logic               til_run,
	output logic               til_sel1,
	input  logic               spr_go,
	input  ts_pkg::ts_coord_t  spr_x,
	input  ts_pkg::ts_size_t   spr_xs,
	input  logic               spr_xf,
	input  ts_pkg::ts_page_t   spr_page,
	input  ts_pkg::ts_row_t    spr_row,
	input  ts_pkg::ts_tnum_t   spr_tnum,
	input  ts_pkg::ts_pal_t    spr_pal,
	input  logic               til_go,
	input  ts_pkg::ts_coord_t  til_x,
	input  ts_pkg::ts_size_t   til_xs,
	input  logic               til_xf,
	input  ts_pkg::ts_page_t   til_page,
	input  ts_pkg::ts_row_t    til_row,
	input  ts_pkg::ts_tnum_t   til_tnum,
	input  ts_pkg::ts_pal_t    til_pal,
	output logic               tsr_go,
	output ts_pkg::ts_coord_t  tsr_x,
	output ts_pkg::ts_size_t   tsr_xs,
	output logic               tsr_xf,
	output ts_pkg::ts_page_t   tsr_page,
	output ts_pkg::ts_row_t    tsr_row,
	output ts_pkg::ts_tnum_t   tsr_tnum,
	output ts_pkg::ts_pal_t    tsr_pal,
	output logic               ts_done
);

	ts_pkg::ts_layer_t layer_r;
	logic              s_en;
	logic              t0_en;
	logic              t1_en;
	logic              layer_switch;

	// next enabled layer after cur
	function automatic ts_pkg::ts_layer_t next_layer(input ts_pkg::ts_layer_t cur,
		input logic se, input logic t0e, input logic t1e);
		case (cur)
			ts_pkg::LAYERS_BEG:
				next_layer = se ? ts_pkg::S0 : t0e ? ts_pkg::T0 :
					t1e ? ts_pkg::T1 : ts_pkg::LAYERS_END;
			ts_pkg::S0:
				next_layer = t0e ? ts_pkg::T0 : se ? ts_pkg::S1 :
					t1e ? ts_pkg::T1 : ts_pkg::LAYERS_END;
			ts_pkg::T0:
				next_layer = se ? ts_pkg::S1 : t1e ? ts_pkg::T1 : ts_pkg::LAYERS_END;
			ts_pkg::S1:
				next_layer = t1e ? ts_pkg::T1 : se ? ts_pkg::S2 : ts_pkg::LAYERS_END;
			ts_pkg::T1:
				next_layer = se ? ts_pkg::S2 : ts_pkg::LAYERS_END;
			default:
				next_layer = ts_pkg::LAYERS_END;
		endcase
	endfunction

	assign s_en  = tsconf[ts_pkg::CFG_S_EN];
	assign t0_en = tsconf[ts_pkg::CFG_T0_EN];
	assign t1_en = tsconf[ts_pkg::CFG_T1_EN];

	assign spr_run  = (layer_r == ts_pkg::S0) || (layer_r == ts_pkg::S1) ||
		(layer_r == ts_pkg::S2);
	assign til_run  = (layer_r == ts_pkg::T0) || (layer_r == ts_pkg::T1);
	assign til_sel1 = layer_r == ts_pkg::T1;
	assign ts_done  = layer_r == ts_pkg::LAYERS_END;

	// only the walker that owns the layer may end it
	assign layer_switch = (spr_run && spr_end) || (til_run && til_end);

	always_ff @(posedge clk)
	begin
		if (rst)
			layer_r <= ts_pkg::LAYERS_END;
		else if (start)
			layer_r <= next_layer(ts_pkg::LAYERS_BEG, s_en, t0_en, t1_en);
		else if (layer_switch)
			layer_r <= next_layer(layer_r, s_en, t0_en, t1_en);
	end

	// renderer bus follows the running walker
	assign tsr_go   = spr_run ? spr_go   : til_go;
	assign tsr_x    = spr_run ? spr_x    : til_x;
	assign tsr_xs   = spr_run ? spr_xs   : til_xs;
	assign tsr_xf   = spr_run ? spr_xf   : til_xf;
	assign tsr_page = spr_run ? spr_page : til_page;
	assign tsr_row  = spr_run ? spr_row  : til_row;
	assign tsr_tnum = spr_run ? spr_tnum : til_tnum;
	assign tsr_pal  = spr_run ? spr_pal  : til_pal;

	assert property (@(posedge clk) disable iff (rst) !(spr_run && til_run));

endmodule

/* tile_walker.sv */
`timescale 1ns/1ps

module tile_walker (
	input  logic                clk,
	input  logic                rst,
	input  logic                start,
	input  logic                run,
	input  logic                sel1,
	input  ts_pkg::ts_coord_t   line,
	input  ts_pkg::ts_tcount_t  num_tiles,
	input  ts_pkg::ts_coord_t   t0x_offs,
	input  ts_pkg::ts_coord_t   t0y_offs,
	input  ts_pkg::ts_coord_t   t1x_offs,
	input  ts_pkg::ts_coord_t   t1y_offs,
	input  ts_pkg::ts_page_t    t0gpage,
	input  ts_pkg::ts_page_t    t1gpage,
	input  logic [1:0]          t0_palsel,
	input  logic [1:0]          t1_palsel,
	input  logic                ready,
	output ts_pkg::ts_tm_addr_t tmb_raddr,
	input  ts_pkg::ts_word_t    tmb_rdata,
	output logic                go,
	output ts_pkg::ts_coord_t   x,
	output ts_pkg::ts_size_t    xs,
	output logic                xf,
	output ts_pkg::ts_page_t    page,
	output ts_pkg::ts_row_t     row,
	output ts_pkg::ts_tnum_t    tnum,
	output ts_pkg::ts_pal_t     pal,
	output logic                layer_end
);

	// tcount_r is the tile whose map entry is on tmb_rdata
	ts_pkg::ts_tcount_t tcount_r;
	ts_pkg::ts_tcount_t tcount_next;
	ts_pkg::ts_tcount_t col;
	logic               armed_r;

	ts_pkg::ts_coord_t x_offs;
	ts_pkg::ts_coord_t y_offs;
	ts_pkg::ts_coord_t yl;
	logic              fresh;
	logic              at_end;
	logic              t_act;
	logic              t_yflp;
	logic              adv;

	logic [ts_pkg::TW_PAL_W-1:0] t_pal;

	assign x_offs = sel1 ? t1x_offs : t0x_offs;
	assign y_offs = sel1 ? t1y_offs : t0y_offs;
	assign yl     = line + y_offs;

	assign tnum   = tmb_rdata[ts_pkg::TW_TNUM_LSB +: $bits(ts_pkg::ts_tnum_t)];
	assign t_pal  = tmb_rdata[ts_pkg::TW_PAL_LSB +: ts_pkg::TW_PAL_W];
	assign t_yflp = tmb_rdata[ts_pkg::TW_YF];
	assign t_act  = tnum != '0;

	// new layer, or run came back after another layer
	assign fresh  = run && !armed_r;
	assign at_end = tcount_r == num_tiles;
	// empty tiles pass without waiting for the renderer
	assign adv    = run && armed_r && !at_end && !(t_act && !ready);

	assign go        = run && armed_r && !at_end && t_act && ready;
	assign layer_end = run && armed_r && at_end;

	always_comb
	begin
		if (start || fresh)
			tcount_next = '0;
		else if (adv)
			tcount_next = tcount_r + 6'd1;
		else
			tcount_next = tcount_r;
	end

	// map column wraps at 64
	assign col       = x_offs[8:3] + tcount_next;
	assign tmb_raddr = {yl[4:3], col, sel1};

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			tcount_r <= '0;
			armed_r  <= 1'b0;
		end
		else
		begin
			tcount_r <= tcount_next;
			armed_r  <= run && !layer_end && !start;
		end
	end

	assign x    = {tcount_r, 3'b000} - {6'b000000, x_offs[2:0]};
	assign xs   = '0;
	assign xf   = tmb_rdata[ts_pkg::TW_XF];
	assign page = sel1 ? t1gpage : t0gpage;
	assign row  = {3'b000, yl[2:0] ^ {3{t_yflp}}};
	assign pal  = {sel1 ? t1_palsel : t0_palsel, t_pal};

	assert property (@(posedge clk) disable iff (rst)
		run && armed_r |-> tcount_r <= num_tiles);

endmodule

/* sprite_walker.sv */
`timescale 1ns/1ps

module sprite_walker (
	input  logic                clk,
	input  logic                rst,
	input  logic                start,
	input  logic                run,
	input  ts_pkg::ts_coord_t   line,
	input  ts_pkg::ts_page_t    sgpage,
	input  logic                ready,
	output ts_pkg::ts_sf_addr_t sf_raddr,
	input  ts_pkg::ts_word_t    sf_rdata,
	output logic                go,
	output ts_pkg::ts_coord_t   x,
	output ts_pkg::ts_size_t    xs,
	output logic                xf,
	output ts_pkg::ts_page_t    page,
	output ts_pkg::ts_row_t     row,
	output ts_pkg::ts_tnum_t    tnum,
	output ts_pkg::ts_pal_t     pal,
	output logic                layer_end
);

	// idx_r is the word now on sf_rdata, stb_r tells R0, R1 or R2
	ts_pkg::ts_sf_addr_t idx_r;
	ts_pkg::ts_sf_addr_t idx_next;
	logic [2:0]          stb_r;
	logic [2:0]          stb_next;
	logic                end_r;

	ts_pkg::ts_coord_t s_ycrd;
	ts_pkg::ts_size_t  s_ysz;
	logic              s_act;
	logic              s_leap;
	logic              s_yflp;
	ts_pkg::ts_coord_t dy;
	logic [6:0]        ylines;
	logic              visible;
	logic              exhausted;
	logic              adv;
	logic              skip;

	// latched R0 and R1 fields
	logic              leap_r;
	ts_pkg::ts_row_t   row_r;
	ts_pkg::ts_coord_t x_r;
	ts_pkg::ts_size_t  xs_r;
	logic              xf_r;

	assign s_ycrd = sf_rdata[ts_pkg::R0_Y_LSB +: $bits(ts_pkg::ts_coord_t)];
	assign s_ysz  = sf_rdata[ts_pkg::R0_YS_LSB +: $bits(ts_pkg::ts_size_t)];
	assign s_act  = sf_rdata[ts_pkg::R0_ACT];
	assign s_leap = sf_rdata[ts_pkg::R0_LEAP];
	assign s_yflp = sf_rdata[ts_pkg::R0_YF];

	// line inside the sprite, wraps at 512
	assign dy      = line - s_ycrd;
	assign ylines  = {1'b0, s_ysz, 3'b000} + 7'd8;
	assign visible = dy < {2'b00, ylines};

	assign exhausted = idx_r == ts_pkg::SF_LAST;
	// only the R2 stage waits for the renderer
	assign adv  = run && !exhausted && !(stb_r[2] && !ready);
	assign skip = adv && stb_r[0] && !(s_act && visible);
	assign go   = stb_r[2] && run && ready;

	// any skipped sprite with leap still closes the layer
	assign layer_end = (go && leap_r) || (skip && s_leap) || (run && exhausted && !end_r);

	always_comb
	begin
		if (start)
		begin
			idx_next = '0;
			stb_next = 3'b001;
		end
		else if (skip)
		begin
			// past R1 and R2 to the next R0
			idx_next = idx_r + 7'd3;
			stb_next = 3'b001;
		end
		else if (adv)
		begin
			idx_next = idx_r + 7'd1;
			stb_next = {stb_r[1:0], stb_r[2]};
		end
		else
		begin
			idx_next = idx_r;
			stb_next = stb_r;
		end
	end

	// the RAM registers this, so its data lines up with idx_r
	assign sf_raddr = idx_next;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			idx_r <= '0;
			stb_r <= 3'b001;
			end_r <= 1'b0;
		end
		else
		begin
			idx_r <= idx_next;
			stb_r <= stb_next;
			end_r <= layer_end;
		end
	end

	always_ff @(posedge clk)
	begin
		if (adv && stb_r[0])
		begin
			leap_r <= s_leap;
			row_r  <= s_yflp ? {s_ysz, 3'b111} - dy[5:0] : dy[5:0];
		end
		if (adv && stb_r[1])
		begin
			x_r  <= sf_rdata[ts_pkg::R1_X_LSB +: $bits(ts_pkg::ts_coord_t)];
			xs_r <= sf_rdata[ts_pkg::R1_XS_LSB +: $bits(ts_pkg::ts_size_t)];
			xf_r <= sf_rdata[ts_pkg::R1_XF];
		end
	end

	assign x    = x_r;
	assign xs   = xs_r;
	assign xf   = xf_r;
	assign page = sgpage;
	assign row  = row_r;
	assign tnum = sf_rdata[ts_pkg::R2_TNUM_LSB +: $bits(ts_pkg::ts_tnum_t)];
	assign pal  = sf_rdata[ts_pkg::R2_PAL_LSB +: $bits(ts_pkg::ts_pal_t)];

	// requests are at least three cycles apart
	assert property (@(posedge clk) disable iff (rst)
		go |-> run && ready && !$past(go) && !$past(go, 2));

endmodule

/* sprite_file.sv */
`timescale 1ns/1ps

module sprite_file (
	input  logic                clk,
	input  ts_pkg::ts_sf_addr_t waddr,
	input  ts_pkg::ts_word_t    wdata,
	input  logic                we,
	input  ts_pkg::ts_sf_addr_t raddr,
	output ts_pkg::ts_word_t    rdata
);

	// descriptor store, written by the host
	ts_pkg::ts_word_t mem [0:ts_pkg::SF_WORDS-1];

	always_ff @(posedge clk)
	begin
		if (we)
		begin
			mem[waddr] <= wdata;
		end
	end

	// registered read, data follows the address by one cycle
	always_ff @(posedge clk)
	begin
		rdata <= mem[raddr];
	end

endmodule

/* ts_pkg.sv */
package ts_pkg;

	// data and address widths
	typedef logic [15:0] ts_word_t;
	typedef logic [6:0]  ts_sf_addr_t;
	typedef logic [8:0]  ts_tm_addr_t;
	typedef logic [8:0]  ts_coord_t;
	// size code, (code + 1) * 8 pixels or lines
	typedef logic [2:0]  ts_size_t;
	typedef logic [11:0] ts_tnum_t;
	typedef logic [3:0]  ts_pal_t;
	typedef logic [7:0]  ts_page_t;
	typedef logic [5:0]  ts_row_t;
	typedef logic [5:0]  ts_tcount_t;

	// layers in the order they are walked within a line
	typedef enum logic [2:0]
	{
		S0         = 3'd0,
		T0         = 3'd1,
		S1         = 3'd2,
		T1         = 3'd3,
		S2         = 3'd4,
		LAYERS_END = 3'd5,
		LAYERS_BEG = 3'd7
	} ts_layer_t;

	// sprite file geometry
	localparam int          SF_WORDS = 128;
	// 42 three-word descriptors, the index stops here
	localparam ts_sf_addr_t SF_LAST  = 7'd126;

	// sprite word R0
	localparam int R0_Y_LSB  = 0;
	localparam int R0_YS_LSB = 9;
	localparam int R0_ACT    = 13;
	localparam int R0_LEAP   = 14;
	localparam int R0_YF     = 15;

	// sprite word R1
	localparam int R1_X_LSB  = 0;
	localparam int R1_XS_LSB = 9;
	localparam int R1_XF     = 15;

	// sprite word R2
	localparam int R2_TNUM_LSB = 0;
	localparam int R2_PAL_LSB  = 12;

	// tile-map entry
	localparam int TW_TNUM_LSB = 0;
	localparam int TW_PAL_LSB  = 12;
	localparam int TW_PAL_W    = 2;
	localparam int TW_XF       = 14;
	localparam int TW_YF       = 15;

	// layer enables in tsconf
	localparam int CFG_S_EN  = 7;
	localparam int CFG_T1_EN = 6;
	localparam int CFG_T0_EN = 5;

endpackage
